/* vlog.f */
+incdir+include
source/cache_pkg.sv
source/cache_req_stage.sv
source/cache_controller.sv
source/cache_datapath.sv
source/cache_top.sv
tb/main_mem_model.sv
tb/cache_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = cache_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status comes from the search for the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/cache_tb.sv */
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_tb;
    import cache_pkg::*;

    localparam int unsigned NUM_REQS  = 600;
    localparam int unsigned REQ_TMO   = 300;    // Cycles for one CPU handshake
    localparam int unsigned FLUSH_TMO = 600;
    localparam int unsigned DRAIN_TMO = 3000;

    typedef struct packed {
        logic [`CACHE_DATA_W-1:0] rdata;
        logic                     hit;
        logic                     is_read;  // Only loads have a defined word
        logic                     timed;    // Hit on an idle cache
        logic [31:0]              due;      // Cycle count of the response
    } exp_resp_t;

    logic                     clk = 1'b0;
    logic                     rst = 1'b0;           // Active low
    logic                     cpu_req_valid = 1'b0;
    cpu_req_t                 cpu_req = '0;
    logic                     flush_req = 1'b0;
    logic                     cpu_req_ready;
    logic                     cpu_resp_valid;
    cpu_resp_t                cpu_resp;
    logic                     flush_done;
    logic                     mem_req_valid;
    logic                     mem_req_ready;
    mem_req_t                 mem_req;
    logic                     mem_rvalid;
    logic [`CACHE_DATA_W-1:0] mem_rdata;

    // Reference cache and memory shadow
    line_t                    model_lines [`CACHE_LINES];
    logic [`CACHE_DATA_W-1:0] shadow [logic [`CACHE_ADDR_W-1:0]];
    exp_resp_t                resp_q [$];
    mem_req_t                 mem_q [$];    // Expected memory traffic in order

    int unsigned cycle_cnt = 0;
    int unsigned transfers = 0;
    int unsigned responses = 0;
    int unsigned mem_writes = 0;
    int unsigned flush_pulses = 0;
    int unsigned errors = 0;
    int unsigned timeouts = 0;
    logic        flushing = 1'b0;

    always #4 clk = ~clk;       // 8 ns period

    cache_top dut_i (
        .clk_i            (clk),
        .rst_i            (rst),
        .cpu_req_valid_i  (cpu_req_valid),
        .cpu_req_ready_o  (cpu_req_ready),
        .cpu_req_i        (cpu_req),
        .cpu_resp_valid_o (cpu_resp_valid),
        .cpu_resp_o       (cpu_resp),
        .flush_req_i      (flush_req),
        .flush_done_o     (flush_done),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_ready_i  (mem_req_ready),
        .mem_req_o        (mem_req),
        .mem_rvalid_i     (mem_rvalid),
        .mem_rdata_i      (mem_rdata)
    );

    main_mem_model mem_i (
        .clk_i           (clk),
        .rst_i           (rst),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_ready_o (mem_req_ready),
        .mem_req_i       (mem_req),
        .mem_rvalid_o    (mem_rvalid),
        .mem_rdata_o     (mem_rdata)
    );

    // Same fill as the memory model
    function automatic logic [`CACHE_DATA_W-1:0] fill_word(
        input logic [`CACHE_ADDR_W-1:0] addr
    );
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_1901;
    endfunction

    function automatic logic [`CACHE_DATA_W-1:0] shadow_word(
        input logic [`CACHE_ADDR_W-1:0] addr
    );
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return fill_word(addr);
    endfunction

    // Three tags over all indices, so lines get hit, replaced and evicted dirty
    function automatic cpu_req_t random_request();
        cpu_req_t r;
        r.addr.tag    = `CACHE_TAG_W'(32'h0012_3400 + ($urandom % 3));
        r.addr.index  = `CACHE_INDEX_W'($urandom);
        r.addr.offset = `CACHE_OFFSET_W'($urandom);
        r.wdata       = $urandom;
        r.write       = ($urandom % 2) == 1;
        return r;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED @ %0t: %s", $time, msg);
    endtask

    // Victim word goes to memory, model memory follows
    task automatic push_writeback(input logic [`CACHE_INDEX_W-1:0] idx);
        mem_req_t op;
        op.addr  = {model_lines[idx].tag, idx, `CACHE_OFFSET_W'(0)};
        op.wdata = model_lines[idx].data;
        op.write = 1'b1;
        mem_q.push_back(op);
        shadow[op.addr] = op.wdata;
    endtask

    // Lookup, eviction, refill and store, in request order
    task automatic model_access(input cpu_req_t req);
        addr_t                    a;
        line_t                    ln;
        mem_req_t                 op;
        exp_resp_t                want;
        logic [`CACHE_ADDR_W-1:0] word_addr;
        a         = req.addr;
        ln        = model_lines[a.index];
        word_addr = {a.tag, a.index, `CACHE_OFFSET_W'(0)};
        want         = '0;
        want.hit     = ln.valid && (ln.tag == a.tag);
        want.is_read = !req.write;
        want.timed   = want.hit && (resp_q.size() == 0);   // Nothing ahead of it
        want.due     = cycle_cnt + 2;
        if (!want.hit) begin
            if (ln.valid && ln.dirty) begin
                push_writeback(a.index);
            end
            op.addr  = word_addr;
            op.wdata = '0;
            op.write = 1'b0;
            mem_q.push_back(op);
            ln.data  = shadow_word(word_addr);
            ln.tag   = a.tag;
            ln.valid = 1'b1;
            ln.dirty = 1'b0;
        end
        want.rdata = ln.data;
        if (req.write) begin
            ln.data  = req.wdata;
            ln.dirty = 1'b1;
        end
        model_lines[a.index] = ln;
        resp_q.push_back(want);
    endtask

    task automatic check_mem_op();
        mem_req_t op;
        if (mem_q.size() == 0) begin
            report_mismatch($sformatf("memory request at %h with none expected", mem_req.addr));
            return;
        end
        op = mem_q.pop_front();
        if (mem_req.write !== op.write) begin
            report_mismatch($sformatf("memory write flag %b, expected %b at %h",
                                      mem_req.write, op.write, op.addr));
        end else if (op.write && (mem_req.addr !== op.addr || mem_req.wdata !== op.wdata)) begin
            report_mismatch($sformatf("write-back %h=%h, expected %h=%h",
                                      mem_req.addr, mem_req.wdata, op.addr, op.wdata));
        end else if (!op.write && (mem_req.addr & ~32'h3) !== op.addr) begin
            report_mismatch($sformatf("refill read at %h, expected %h", mem_req.addr, op.addr));
        end
    endtask

    // Monitor on the rising edge, responses before new transfers
    always @(posedge clk) begin
        exp_resp_t want;
        cycle_cnt++;
        if (rst) begin
            if (cpu_resp_valid) begin
                responses++;
                if (resp_q.size() == 0) begin
                    report_mismatch("response with no request outstanding");
                end else begin
                    want = resp_q.pop_front();
                    if (cpu_resp.hit !== want.hit) begin
                        report_mismatch($sformatf("hit flag %b, expected %b",
                                                  cpu_resp.hit, want.hit));
                    end
                    if (want.is_read && cpu_resp.rdata !== want.rdata) begin
                        report_mismatch($sformatf("read data %h, expected %h",
                                                  cpu_resp.rdata, want.rdata));
                    end
                    if (want.timed && cycle_cnt != want.due) begin
                        report_mismatch($sformatf("hit response in cycle %0d, expected %0d",
                                                  cycle_cnt, want.due));
                    end
                end
            end
            if (cpu_req_valid && cpu_req_ready) begin
                transfers++;
                model_access(cpu_req);
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.write) mem_writes++;
                check_mem_op();
            end
            if (flush_done) begin
                flush_pulses++;
                if (!flushing) report_mismatch("flush done pulse outside a flush");
            end
        end
    end

    task automatic send_request(input cpu_req_t req, output logic ok);
        int unsigned wait_cnt;
        wait_cnt      = 0;
        ok            = 1'b0;
        cpu_req       = req;
        cpu_req_valid = 1'b1;
        while (!ok && wait_cnt < REQ_TMO) begin
            @(posedge clk);
            ok = cpu_req_ready;     // Transfer on this edge
            wait_cnt++;
        end
        @(negedge clk);
        cpu_req_valid = 1'b0;
        if (!ok) begin
            timeouts++;
            $display("Timeout: request to %h not accepted in %0d cycles", req.addr, REQ_TMO);
        end
    endtask

    task automatic wait_drain(output logic ok);
        int unsigned wait_cnt;
        wait_cnt = 0;
        while (resp_q.size() != 0 && wait_cnt < DRAIN_TMO) begin
            @(negedge clk);
            wait_cnt++;
        end
        ok = (resp_q.size() == 0);
        if (!ok) begin
            timeouts++;
            $display("Timeout: %0d responses still missing", resp_q.size());
        end
    endtask

    // Model walks lines 0 to 7 up front, DUT follows in the same order
    task automatic run_flush(output logic ok);
        int unsigned wait_cnt;
        int unsigned pulses_before;
        int          i;
        wait_cnt      = 0;
        ok            = 1'b0;
        pulses_before = flush_pulses;
        for (i = 0; i < `CACHE_LINES; i++) begin
            if (model_lines[i].valid && model_lines[i].dirty) begin
                push_writeback(`CACHE_INDEX_W'(i));
            end
            model_lines[i].valid = 1'b0;
            model_lines[i].dirty = 1'b0;
        end
        flushing  = 1'b1;
        flush_req = 1'b1;
        while (!ok && wait_cnt < FLUSH_TMO) begin
            @(posedge clk);
            ok = flush_done;
            wait_cnt++;
        end
        @(negedge clk);
        flush_req = 1'b0;
        repeat (2) @(negedge clk);      // Room for a stray second pulse
        flushing = 1'b0;
        if (!ok) begin
            timeouts++;
            $display("Timeout: flush did not finish in %0d cycles", FLUSH_TMO);
        end else begin
            if (flush_pulses != pulses_before + 1) begin
                report_mismatch($sformatf("%0d flush done pulses, expected 1",
                                          flush_pulses - pulses_before));
            end
            if (mem_q.size() != 0) begin
                report_mismatch($sformatf("%0d write-backs missing after flush", mem_q.size()));
            end
        end
    endtask

    initial begin
        cpu_req_t    req;
        logic        ok;
        int unsigned gap;
        int unsigned n;
        int          i;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'h1901));
        for (i = 0; i < `CACHE_LINES; i++) begin
            model_lines[i] = '0;
        end
        ok = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b1;
        @(posedge clk);
        if (cpu_resp_valid !== 1'b0 || mem_req_valid !== 1'b0 || flush_done !== 1'b0) begin
            report_mismatch("outputs not idle after reset");
        end
        if (cpu_req_ready !== 1'b1) report_mismatch("request port not ready after reset");
        @(negedge clk);
        n = 0;
        while (ok && n < NUM_REQS) begin
            if (n == NUM_REQS / 2 || ($urandom % 60) == 0) begin
                wait_drain(ok);
                if (ok) run_flush(ok);
            end
            if (ok) begin
                req = random_request();
                send_request(req, ok);
                gap = (($urandom % 4) == 0) ? ($urandom % 5) : 0;   // Mostly back to back
                repeat (gap) @(negedge clk);
            end
            n++;
        end
        if (ok) wait_drain(ok);
        if (ok) run_flush(ok);
        // One load per index after the flush, each must miss
        for (i = 0; ok && i < `CACHE_LINES; i++) begin
            req            = random_request();
            req.addr.index = `CACHE_INDEX_W'(i);
            req.write      = 1'b0;
            send_request(req, ok);
        end
        if (ok) wait_drain(ok);
        if (transfers != responses) begin
            report_mismatch($sformatf("%0d transfers but %0d responses", transfers, responses));
        end
        $display("Transfers %0d, responses %0d, memory writes %0d",
                 transfers, responses, mem_writes);
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb/main_mem_model.sv */
`timescale 1ns/1ps

`include "cache_params.svh"

module main_mem_model (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     mem_req_valid_i,
    output logic                     mem_req_ready_o,
    input  cache_pkg::mem_req_t      mem_req_i,
    output logic                     mem_rvalid_o,
    output logic [`CACHE_DATA_W-1:0] mem_rdata_o
);
    import cache_pkg::*;

    logic [`CACHE_DATA_W-1:0] words [logic [`CACHE_ADDR_W-1:0]];   // Written words only
    logic [`CACHE_ADDR_W-1:0] read_addr = '0;     // Word address of the read in flight
    logic                     took_read = 1'b0;   // Read accepted on the last rising edge
    logic                     read_pending = 1'b0;
    int unsigned              read_delay = 0;
    logic                     ready_q = 1'b0;
    logic                     rvalid_q = 1'b0;
    logic [`CACHE_DATA_W-1:0] rdata_q = '0;

    assign mem_req_ready_o = ready_q;
    assign mem_rvalid_o    = rvalid_q;
    assign mem_rdata_o     = rdata_q;

    // Never written words, mixed from every address bit
    function automatic logic [`CACHE_DATA_W-1:0] fill_word(
        input logic [`CACHE_ADDR_W-1:0] addr
    );
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_1901;
    endfunction

    function automatic logic [`CACHE_DATA_W-1:0] read_word(
        input logic [`CACHE_ADDR_W-1:0] addr
    );
        if (words.exists(addr)) begin
            return words[addr];
        end
        return fill_word(addr);
    endfunction

    // Handshake seen on the rising edge
    always @(posedge clk_i) begin
        took_read = 1'b0;
        if (rst_i && mem_req_valid_i && ready_q) begin
            if (mem_req_i.write) begin
                words[mem_req_i.addr & ~32'h3] = mem_req_i.wdata;   // Done at transfer
            end else begin
                took_read = 1'b1;
                read_addr = mem_req_i.addr & ~32'h3;                // Offset dropped
            end
        end
    end

    // Outputs change on the falling edge only
    always @(negedge clk_i) begin
        rvalid_q <= 1'b0;
        if (!rst_i) begin
            ready_q      <= 1'b0;
            read_pending = 1'b0;
        end else begin
            if (took_read) begin
                read_pending = 1'b1;
                read_delay   = $urandom_range(5, 0);    // 1 to 6 cycles
            end
            if (read_pending) begin
                if (read_delay == 0) begin
                    rvalid_q     <= 1'b1;
                    rdata_q      <= read_word(read_addr);
                    read_pending = 1'b0;
                end else begin
                    read_delay--;
                end
            end
            ready_q <= ($urandom % 4) != 0;     // Stall about a quarter of cycles
        end
    end

endmodule

/* source/cache_top.sv */
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_top (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     cpu_req_valid_i,
    output logic                     cpu_req_ready_o,
    input  cache_pkg::cpu_req_t      cpu_req_i,
    output logic                     cpu_resp_valid_o,
    output cache_pkg::cpu_resp_t     cpu_resp_o,
    input  logic                     flush_req_i,
    output logic                     flush_done_o,
    output logic                     mem_req_valid_o,
    input  logic                     mem_req_ready_i,
    output cache_pkg::mem_req_t      mem_req_o,
    input  logic                     mem_rvalid_i,
    input  logic [`CACHE_DATA_W-1:0] mem_rdata_i
);
    import cache_pkg::*;

    // Stage to controller
    logic     stg_valid;
    logic     stg_ready;
    cpu_req_t stg_req;

    // Controller and datapath
    dp_ctrl_t                 dp_ctrl;
    addr_t                    ctrl_addr;
    logic [`CACHE_DATA_W-1:0] ctrl_wdata;
    logic                     dp_hit;
    logic                     dp_dirty;
    addr_t                    dp_victim_addr;
    logic [`CACHE_DATA_W-1:0] dp_victim_data;
    logic                     dp_flush_last;

    cache_req_stage req_stage_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (cpu_req_valid_i),
        .in_ready_o  (cpu_req_ready_o),
        .in_req_i    (cpu_req_i),
        .out_valid_o (stg_valid),
        .out_ready_i (stg_ready),
        .out_req_o   (stg_req)
    );

    cache_controller controller_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .req_valid_i      (stg_valid),
        .req_ready_o      (stg_ready),
        .req_i            (stg_req),
        .flush_req_i      (flush_req_i),
        .flush_done_o     (flush_done_o),
        .hit_i            (dp_hit),
        .dirty_i          (dp_dirty),
        .victim_addr_i    (dp_victim_addr),
        .victim_data_i    (dp_victim_data),
        .flush_last_i     (dp_flush_last),
        .ctrl_o           (dp_ctrl),
        .addr_o           (ctrl_addr),
        .wdata_o          (ctrl_wdata),
        .cpu_resp_valid_o (cpu_resp_valid_o),
        .cpu_resp_o       (cpu_resp_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_o        (mem_req_o),
        .mem_rvalid_i     (mem_rvalid_i)
    );

    cache_datapath datapath_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .ctrl_i        (dp_ctrl),
        .addr_i        (ctrl_addr),
        .wdata_i       (ctrl_wdata),
        .fill_data_i   (mem_rdata_i),       // Refill word straight from memory
        .hit_o         (dp_hit),
        .dirty_o       (dp_dirty),
        .rdata_o       (),                  // Response word comes with the victim data
        .victim_addr_o (dp_victim_addr),
        .victim_data_o (dp_victim_data),
        .flush_last_o  (dp_flush_last)
    );

endmodule

/* source/cache_datapath.sv */
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_datapath (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  cache_pkg::dp_ctrl_t      ctrl_i,
    input  cache_pkg::addr_t         addr_i,
    input  logic [`CACHE_DATA_W-1:0] wdata_i,
    input  logic [`CACHE_DATA_W-1:0] fill_data_i,
    output logic                     hit_o,
    output logic                     dirty_o,
    output logic [`CACHE_DATA_W-1:0] rdata_o,
    output cache_pkg::addr_t         victim_addr_o,
    output logic [`CACHE_DATA_W-1:0] victim_data_o,
    output logic                     flush_last_o
);
    import cache_pkg::*;

    line_t                         lines_q [`CACHE_LINES];
    logic [`CACHE_FLUSH_CNT_W-1:0] flush_cnt_q;    // Line under flush
    logic [`CACHE_INDEX_W-1:0]     sel_idx;
    line_t                         idx_line;       // Line of the request
    line_t                         sel_line;       // Request line or flush line

    assign sel_idx  = ctrl_i.flush_active ? flush_cnt_q[`CACHE_INDEX_W-1:0] : addr_i.index;
    assign idx_line = lines_q[addr_i.index];
    assign sel_line = lines_q[sel_idx];

    // Tag compare
    assign hit_o   = idx_line.valid && (idx_line.tag == addr_i.tag);
    assign rdata_o = idx_line.data;
    assign dirty_o = sel_line.dirty;

    // Word aligned write-back address rebuilt from the stored tag
    assign victim_addr_o.tag    = sel_line.tag;
    assign victim_addr_o.index  = sel_idx;
    assign victim_addr_o.offset = '0;
    assign victim_data_o        = sel_line.data;

    assign flush_last_o = (flush_cnt_q == `CACHE_FLUSH_CNT_W'(`CACHE_LINES - 1));

    // Store takes priority over refill and flush step
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            for (int i = 0; i < `CACHE_LINES; i++) begin
                lines_q[i].valid <= 1'b0;
                lines_q[i].dirty <= 1'b0;
            end
        end else if (ctrl_i.cpu_write) begin
            lines_q[addr_i.index].data  <= wdata_i;
            lines_q[addr_i.index].valid <= 1'b1;
            lines_q[addr_i.index].dirty <= 1'b1;
        end else if (ctrl_i.fill) begin
            lines_q[addr_i.index].data  <= fill_data_i;
            lines_q[addr_i.index].tag   <= addr_i.tag;
            lines_q[addr_i.index].valid <= 1'b1;
            lines_q[addr_i.index].dirty <= 1'b0;
        end else if (ctrl_i.flush_step) begin
            // Dirty line drops only once written back
            if (!sel_line.dirty || ctrl_i.clear_dirty) begin
                lines_q[sel_idx].valid <= 1'b0;
                lines_q[sel_idx].dirty <= 1'b0;
            end
        end
    end

    // Flush walk parked at line 0 outside a flush
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            flush_cnt_q <= '0;
        end else if (!ctrl_i.flush_active) begin
            flush_cnt_q <= '0;
        end else if (ctrl_i.flush_step) begin
            flush_cnt_q <= flush_cnt_q + 1'b1;
        end
    end

    // Controller must leave the flush at the last line
    assert property (@(posedge clk_i) disable iff (!rst_i)
        ctrl_i.flush_active |-> flush_cnt_q < `CACHE_FLUSH_CNT_W'(`CACHE_LINES));

endmodule

/* source/cache_controller.sv */
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_controller (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  cache_pkg::cpu_req_t      req_i,
    input  logic                     flush_req_i,
    output logic                     flush_done_o,
    input  logic                     hit_i,
    input  logic                     dirty_i,
    input  cache_pkg::addr_t         victim_addr_i,
    input  logic [`CACHE_DATA_W-1:0] victim_data_i,
    input  logic                     flush_last_i,
    output cache_pkg::dp_ctrl_t      ctrl_o,
    output cache_pkg::addr_t         addr_o,
    output logic [`CACHE_DATA_W-1:0] wdata_o,
    output logic                     cpu_resp_valid_o,
    output cache_pkg::cpu_resp_t     cpu_resp_o,
    output logic                     mem_req_valid_o,
    input  logic                     mem_req_ready_i,
    output cache_pkg::mem_req_t      mem_req_o,
    input  logic                     mem_rvalid_i
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL_REQ,
        ST_REFILL_WAIT,
        ST_FLUSH
    } state_t;

    state_t   state_q;
    cpu_req_t req_q;        // Request in service
    logic     missed_q;     // Lookup went to memory
    logic     req_fire;

    assign req_ready_o = (state_q == ST_IDLE) && !flush_req_i;     // Flush wins
    assign req_fire    = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            state_q  <= ST_IDLE;
            missed_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (flush_req_i) begin
                        state_q <= ST_FLUSH;
                    end else if (req_valid_i) begin
                        state_q  <= ST_LOOKUP;
                        missed_q <= 1'b0;
                    end
                end
                ST_LOOKUP: begin
                    if (hit_i) begin
                        state_q <= ST_IDLE;             // Response goes out now
                    end else begin
                        missed_q <= 1'b1;
                        state_q  <= dirty_i ? ST_WRITEBACK : ST_REFILL_REQ;
                    end
                end
                ST_WRITEBACK:   if (mem_req_ready_i) state_q <= ST_REFILL_REQ;
                ST_REFILL_REQ:  if (mem_req_ready_i) state_q <= ST_REFILL_WAIT;
                ST_REFILL_WAIT: if (mem_rvalid_i) state_q <= ST_LOOKUP;   // Retry as hit
                ST_FLUSH:       if (flush_done_o) state_q <= ST_IDLE;
                default:        state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_q <= req_i;
        end
    end

    always_comb begin
        ctrl_o              = '0;
        ctrl_o.cpu_write    = (state_q == ST_LOOKUP) && hit_i && req_q.write;
        ctrl_o.fill         = (state_q == ST_REFILL_WAIT) && mem_rvalid_i;
        ctrl_o.flush_active = (state_q == ST_FLUSH);
        // Clean line steps at once and dirty line after its write
        ctrl_o.flush_step   = (state_q == ST_FLUSH) && (!dirty_i || mem_req_ready_i);
        ctrl_o.clear_dirty  = (state_q == ST_FLUSH) && dirty_i && mem_req_ready_i;
    end

    assign addr_o       = req_q.addr;
    assign wdata_o      = req_q.wdata;
    assign flush_done_o = ctrl_o.flush_step && flush_last_i;

    assign cpu_resp_valid_o = (state_q == ST_LOOKUP) && hit_i;
    assign cpu_resp_o.rdata = victim_data_i;    // Indexed word outside a flush
    assign cpu_resp_o.hit   = !missed_q;

    assign mem_req_valid_o = (state_q == ST_WRITEBACK) || (state_q == ST_REFILL_REQ)
                          || ((state_q == ST_FLUSH) && dirty_i);
    assign mem_req_o.addr  = (state_q == ST_REFILL_REQ) ? req_q.addr : victim_addr_i;
    assign mem_req_o.wdata = victim_data_i;
    assign mem_req_o.write = (state_q != ST_REFILL_REQ);

    // Memory request held until taken
    assert property (@(posedge clk_i) disable iff (!rst_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule

/* source/cache_req_stage.sv */
`timescale 1ns/1ps

module cache_req_stage (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  cache_pkg::cpu_req_t in_req_i,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output cache_pkg::cpu_req_t out_req_o
);
    import cache_pkg::*;

    cpu_req_t req_q;        // Held request
    logic     valid_q;
    logic     in_fire;

    // Empty, or the entry leaves this cycle
    assign in_ready_o = !valid_q || out_ready_i;
    assign in_fire    = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            valid_q <= 1'b0;
        end else if (in_fire) begin
            valid_q <= 1'b1;            // New entry, maybe replacing a leaving one
        end else if (out_ready_i) begin
            valid_q <= 1'b0;            // Drained
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            req_q <= in_req_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_req_o   = req_q;

    // A stalled entry stays put
    assert property (@(posedge clk_i) disable iff (!rst_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_req_o));

endmodule

/* source/cache_pkg.sv */
`include "cache_params.svh"

package cache_pkg;

    // Address split, tag in the top bits
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
    } addr_t;

    typedef struct packed {
        addr_t                    addr;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic                     write;    // 1 for a store
    } cpu_req_t;

    typedef struct packed {
        logic [`CACHE_DATA_W-1:0] rdata;
        logic                     hit;      // Served without memory traffic
    } cpu_resp_t;

    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic                     write;    // 0 for a refill read
    } mem_req_t;

    typedef struct packed {
        logic [`CACHE_DATA_W-1:0] data;
        logic [`CACHE_TAG_W-1:0]  tag;
        logic                     valid;
        logic                     dirty;
    } line_t;

    // Controller commands to the datapath
    typedef struct packed {
        logic cpu_write;        // Store word into indexed line
        logic fill;             // Load refill word and tag
        logic flush_active;     // Flush counter selects the line
        logic flush_step;       // Advance the walk
        logic clear_dirty;      // Written back line is dropped
    } dp_ctrl_t;

endpackage

/* include/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Word and address sizes
`define CACHE_ADDR_W      32
`define CACHE_DATA_W      32

// Direct mapped geometry, one word per line
`define CACHE_LINES       8
`define CACHE_TAG_W       27
`define CACHE_INDEX_W     3
`define CACHE_OFFSET_W    2       // Byte offset, carried only

// Flush walk counter
// One bit wider than the index so the walk end is visible
`define CACHE_FLUSH_CNT_W (`CACHE_INDEX_W + 1)

`endif
